// ==== axis_adapt_pkg.sv ====
/* AXI-stream upsizer shared definitions
   Widths, narrow beat and wide word structs, controller states */

package axis_adapt_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // Bytes per narrow input beat
    localparam int in_bytes = 2;

    // Bytes per packed output word
    localparam int out_bytes = 8;

    // Narrow beats that fill one wide word
    localparam int subwords = out_bytes / in_bytes;

    // Beat counter holds 0 .. subwords-1
    localparam int cnt_w = $clog2(subwords);

    // Sideband widths
    localparam int dest_w = 4;
    localparam int user_w = 2;

    ////////////////////////////////////////////////////////////
    // Stream payloads
    ////////////////////////////////////////////////////////////

    // One narrow beat as seen on the input side
    typedef struct packed {
        logic [in_bytes*8-1:0] data;
        logic [in_bytes-1:0]   keep;
        logic                  last;
        logic [dest_w-1:0]     dest;
        logic [user_w-1:0]     user;
    } narrow_beat_t;

    // One packed wide word
    // Sideband comes from the beat that closed the word
    typedef struct packed {
        logic [out_bytes*8-1:0] data;
        logic [out_bytes-1:0]   keep;
        logic                   last;
        logic [dest_w-1:0]      dest;
        logic [user_w-1:0]      user;
    } wide_word_t;

    ////////////////////////////////////////////////////////////
    // Controller states
    ////////////////////////////////////////////////////////////

    // st_fill  accepting narrow beats
    // st_emit  moving a finished word to the output register
    typedef enum logic {
        st_fill = 1'b0,
        st_emit = 1'b1
    } pack_state_e;

endpackage

// ==== axis_pack_ctrl.sv ====
/* Upsizer controller FSM
   Sequences beat acceptance and hand-off of finished words */

`timescale 1ns/1ps

module axis_pack_ctrl (
    input  logic axis_in,
    input  logic rst_n,
    input  logic s_valid,
    input  logic s_last,
    input  logic final_slot,
    input  logic out_free,
    output logic s_ready,
    output logic shift_en,
    output logic word_done
);

    import axis_adapt_pkg::*;

    pack_state_e state;
    pack_state_e state_nxt;

    // Accepted beat closes the word
    logic close_beat;

    ////////////////////////////////////////////////////////////
    // Handshake decode
    ////////////////////////////////////////////////////////////

    // Input only open while filling
    assign s_ready = (state == st_fill);

    // Input handshake this cycle
    assign shift_en = s_valid && s_ready;

    // Last flag or fourth beat ends the word
    assign close_beat = shift_en && (s_last || final_slot);

    // Move to output once the holding register can take it
    assign word_done = (state == st_emit) && out_free;

    ////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            st_fill: begin
                if (close_beat) begin
                    state_nxt = st_emit;
                end
            end
            st_emit: begin
                // Finished word waits in the shifter until out_free
                if (out_free) begin
                    state_nxt = st_fill;
                end
            end
            default: begin
                state_nxt = st_fill;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // State register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_in) begin
        if (!rst_n) begin
            state <= st_fill;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

// ==== axis_pack_shifter.sv ====
/* Packing shift register for the upsizer
   Shifts narrow data and keep into a wide word, keeps closing sideband */

`timescale 1ns/1ps

module axis_pack_shifter (
    input  logic                        axis_in,
    input  logic                        rst_n,
    input  axis_adapt_pkg::narrow_beat_t s_beat,
    input  logic                        shift_en,
    input  logic                        word_done,
    output axis_adapt_pkg::wide_word_t   packed_word
);

    import axis_adapt_pkg::*;

    // Bits of data and keep that survive one shift
    localparam int keep_hi = out_bytes - in_bytes;
    localparam int data_hi = (out_bytes - in_bytes) * 8;

    // Word under construction
    wide_word_t word_q;

    ////////////////////////////////////////////////////////////
    // Shift register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_in) begin
        if (!rst_n) begin
            word_q <= '0;
        end else if (word_done) begin
            // Zero data and keep so a short word gets empty upper lanes
            word_q <= '0;
        end else if (shift_en) begin
            // Older beats move up one subword, newest enters at subword 0
            word_q.data <= {word_q.data[data_hi-1:0], s_beat.data};
            word_q.keep <= {word_q.keep[keep_hi-1:0], s_beat.keep};

            // Sideband follows every beat, so the closing one wins
            word_q.last <= s_beat.last;
            word_q.dest <= s_beat.dest;
            word_q.user <= s_beat.user;
        end
    end

    assign packed_word = word_q;

endmodule

// ==== axis_subword_counter.sv ====
/* Subword counter for the upsizer
   Counts accepted beats of the current word and flags the last slot */

`timescale 1ns/1ps

module axis_subword_counter (
    input  logic axis_in,
    input  logic rst_n,
    input  logic shift_en,
    input  logic word_done,
    output logic final_slot
);

    import axis_adapt_pkg::*;

    // Beats already packed into the current word
    logic [cnt_w-1:0] beat_cnt;

    ////////////////////////////////////////////////////////////
    // Count register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_in) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (word_done) begin
            // Word handed off, start over
            beat_cnt <= '0;
        end else if (shift_en) begin
            // Wraps after the fourth beat, controller leaves st_fill then anyway
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // Next accepted beat lands in the top subword
    assign final_slot = (beat_cnt == cnt_w'(subwords - 1));

endmodule

// ==== axis_upsizer.sv ====
/* AXI-stream 16 to 64 bit upsizer top level
   Counter, controller, shifter and output register */

`timescale 1ns/1ps

module axis_upsizer (
    input  logic                        axis_in,
    input  logic                        rst_n,
    input  axis_adapt_pkg::narrow_beat_t s_beat,
    input  logic                        s_valid,
    output logic                        s_ready,
    output axis_adapt_pkg::wide_word_t   m_word,
    output logic                        m_valid,
    input  logic                        m_ready
);

    import axis_adapt_pkg::*;

    ////////////////////////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////////////////////////

    logic       shift_en;
    logic       word_done;
    logic       final_slot;
    logic       out_free;
    wide_word_t packed_word;

    axis_subword_counter u_counter (
        .axis_in    (axis_in),
        .rst_n      (rst_n),
        .shift_en   (shift_en),
        .word_done  (word_done),
        .final_slot (final_slot)
    );

    // Controller sees only the last bit of the beat
    axis_pack_ctrl u_ctrl (
        .axis_in    (axis_in),
        .rst_n      (rst_n),
        .s_valid    (s_valid),
        .s_last     (s_beat.last),
        .final_slot (final_slot),
        .out_free   (out_free),
        .s_ready    (s_ready),
        .shift_en   (shift_en),
        .word_done  (word_done)
    );

    axis_pack_shifter u_shifter (
        .axis_in     (axis_in),
        .rst_n       (rst_n),
        .s_beat      (s_beat),
        .shift_en    (shift_en),
        .word_done   (word_done),
        .packed_word (packed_word)
    );

    axis_word_out_reg u_out_reg (
        .axis_in     (axis_in),
        .rst_n       (rst_n),
        .packed_word (packed_word),
        .word_done   (word_done),
        .m_ready     (m_ready),
        .m_word      (m_word),
        .m_valid     (m_valid),
        .out_free    (out_free)
    );

endmodule

// ==== axis_upsizer_chk.sv ====
/* Handshake assertions for the upsizer
   Bound into the top level, watches reset, hold and close rules */

`timescale 1ns/1ps

module axis_upsizer_chk (
    input logic                        axis_in,
    input logic                        rst_n,
    input axis_adapt_pkg::narrow_beat_t s_beat,
    input logic                        s_valid,
    input logic                        s_ready,
    input axis_adapt_pkg::wide_word_t   m_word,
    input logic                        m_valid,
    input logic                        m_ready,
    input logic                        final_slot
);

    // Failed assertions so far
    int fail_cnt = 0;

    // Output empty right after a reset cycle
    assert property (@(posedge axis_in) !rst_n |=> !m_valid)
        else begin
            $error("m_valid high in the cycle after reset");
            fail_cnt++;
        end

    // Held word must not move under back-pressure
    assert property (@(posedge axis_in) disable iff (!rst_n)
        (m_valid && !m_ready) |=> $stable(m_word))
        else begin
            $error("m_word changed while stalled");
            fail_cnt++;
        end

    // Closing beat sends the FSM to st_emit, input closes
    assert property (@(posedge axis_in) disable iff (!rst_n)
        (s_valid && s_ready && (s_beat.last || final_slot)) |=> !s_ready)
        else begin
            $error("s_ready high after a closing beat");
            fail_cnt++;
        end

    // Every emitted word carries at least one byte
    assert property (@(posedge axis_in) disable iff (!rst_n)
        m_valid |-> (m_word.keep != '0))
        else begin
            $error("m_word.keep all zero while valid");
            fail_cnt++;
        end

endmodule

bind axis_upsizer axis_upsizer_chk chk0 (
    .axis_in    (axis_in),
    .rst_n      (rst_n),
    .s_beat     (s_beat),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .m_word     (m_word),
    .m_valid    (m_valid),
    .m_ready    (m_ready),
    .final_slot (final_slot)
);

// ==== axis_word_out_reg.sv ====
/* Output holding register of the upsizer
   Holds a packed word and valid stable under back-pressure */

`timescale 1ns/1ps

module axis_word_out_reg (
    input  logic                      axis_in,
    input  logic                      rst_n,
    input  axis_adapt_pkg::wide_word_t packed_word,
    input  logic                      word_done,
    input  logic                      m_ready,
    output axis_adapt_pkg::wide_word_t m_word,
    output logic                      m_valid,
    output logic                      out_free
);

    ////////////////////////////////////////////////////////////
    // Valid flag
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_in) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
        end else if (word_done) begin
            // A new load wins over a handshake in the same cycle
            m_valid <= 1'b1;
        end else if (m_valid && m_ready) begin
            m_valid <= 1'b0;
        end
    end

    // Payload only changes on a load
    always_ff @(posedge axis_in) begin
        if (word_done) begin
            m_word <= packed_word;
        end
    end

    // Empty now, or the sink takes the held word this cycle
    assign out_free = !m_valid || m_ready;

endmodule

// ==== tb_axis_upsizer.sv ====
/* Testbench for the AXI-stream upsizer
   Random beats and back-pressure checked against a packing model */

`timescale 1ns/1ps

module tb_axis_upsizer;

    import axis_adapt_pkg::*;

    logic         axis_in;
    logic         rst_n;
    narrow_beat_t s_beat;
    logic         s_valid;
    logic         s_ready;
    wide_word_t   m_word;
    logic         m_valid;
    logic         m_ready;

    integer       seed = 32'h8ec9;
    narrow_beat_t beat_q[$];
    int           gap_q[$];
    wide_word_t   exp_q[$];
    narrow_beat_t cur_beats [0:3];
    logic         rdy_pat [0:1023];
    int cur_cnt, rdy_idx, edge_cnt, close_edge, exp_total, rx_count;
    int payload_err, sideband_err, assert_err, other_err;
    logic mv_prev, lat_mode, lat_check, timed_out;

    tb_clk_gen clk0 (.axis_in(axis_in), .rst_n(rst_n));

    axis_upsizer dut0 (
        .axis_in (axis_in),
        .rst_n   (rst_n),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_word  (m_word),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    ////////////////////////////////////////////////////////////
    // Model and compare tasks
    ////////////////////////////////////////////////////////////

    // First beat highest, newest beat in subword 0, rest zero
    function automatic wide_word_t pack_model(input narrow_beat_t beats [0:3], input int n);
        wide_word_t w;
        int i;
        w = '0;
        for (i = 0; i < n; i++) begin
            w.data[(n-1-i)*in_bytes*8 +: in_bytes*8] = beats[i].data;
            w.keep[(n-1-i)*in_bytes +: in_bytes] = beats[i].keep;
        end
        // Sideband of the closing beat
        w.last = beats[n-1].last;
        w.dest = beats[n-1].dest;
        w.user = beats[n-1].user;
        return w;
    endfunction

    task automatic check_payload(input wide_word_t exp_w, input wide_word_t act_w);
        if (act_w.data !== exp_w.data) begin
            $display("error: m_word.data expected %h actual %h", exp_w.data, act_w.data);
            payload_err++;
        end
        if (act_w.keep !== exp_w.keep) begin
            $display("error: m_word.keep expected %h actual %h", exp_w.keep, act_w.keep);
            payload_err++;
        end
        if (act_w.last !== exp_w.last) begin
            $display("error: m_word.last expected %h actual %h", exp_w.last, act_w.last);
            payload_err++;
        end
    endtask

    task automatic check_sideband(input wide_word_t exp_w, input wide_word_t act_w);
        if (act_w.dest !== exp_w.dest) begin
            $display("error: m_word.dest expected %h actual %h", exp_w.dest, act_w.dest);
            sideband_err++;
        end
        if (act_w.user !== exp_w.user) begin
            $display("error: m_word.user expected %h actual %h", exp_w.user, act_w.user);
            sideband_err++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("error: %s expected %h actual %h", name, exp_v, act_v);
            other_err++;
        end
    endtask

    task automatic check_count(input string name, input int exp_v, input int act_v);
        if (act_v != exp_v) begin
            $display("error: %s expected %h actual %h", name, exp_v, act_v);
            other_err++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Monitor, sampled on the rising edge
    ////////////////////////////////////////////////////////////

    always @(posedge axis_in) begin
        edge_cnt++;
        if (rst_n) begin
            // Rise of m_valid two edges after the closing handshake
            if (lat_check && m_valid && !mv_prev) begin
                check_count("m_valid latency", 2, edge_cnt - close_edge);
            end
            if (m_valid && m_ready) begin
                rx_count++;
                if (exp_q.size() == 0) begin
                    $display("output word arrived with no word expected");
                    other_err++;
                end else begin
                    check_payload(exp_q[0], m_word);
                    check_sideband(exp_q[0], m_word);
                    void'(exp_q.pop_front());
                end
            end
            // Accepted beat goes into the model, closes on last or fourth beat
            if (s_valid && s_ready) begin
                cur_beats[cur_cnt] = s_beat;
                cur_cnt++;
                if (s_beat.last || cur_cnt == subwords) begin
                    exp_q.push_back(pack_model(cur_beats, cur_cnt));
                    exp_total++;
                    close_edge = edge_cnt;
                    cur_cnt = 0;
                end
            end
        end
        mv_prev = m_valid;
    end

    // Sink ready from the random pattern, or always high in latency mode
    always @(negedge axis_in) begin
        if (lat_mode) begin
            m_ready = 1'b1;
        end else begin
            m_ready = rdy_pat[rdy_idx];
            rdy_idx = (rdy_idx + 1) % 1024;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // Words of 1 to 4 beats, only the fourth beat of a full word may lack last
    task automatic gen_words(input int n_words);
        narrow_beat_t b;
        logic [31:0] r;
        int w, i, n_beats;
        for (w = 0; w < n_words; w++) begin
            r = $random(seed);
            n_beats = 1 + r % 4;
            for (i = 0; i < n_beats; i++) begin
                r = $random(seed);
                b.data = r[15:0];
                b.keep = (r[17:16] == 2'b00) ? 2'b11 : r[17:16];
                b.dest = r[21:18];
                b.user = r[23:22];
                b.last = (i == n_beats - 1) && (n_beats < subwords || r[25:24] == 2'b00);
                beat_q.push_back(b);
                gap_q.push_back((r[27:26] == 2'b00) ? 1 + r[28] : 0);
            end
        end
    endtask

    // Entered on a falling edge; s_ready only moves on rising edges
    task automatic send_all();
        int gap, waited;
        while (beat_q.size() > 0 && !timed_out) begin
            gap = gap_q.pop_front();
            s_valid = 1'b0;
            repeat (gap) @(negedge axis_in);
            s_beat = beat_q.pop_front();
            s_valid = 1'b1;
            waited = 0;
            while (!s_ready && waited < 200) begin
                @(negedge axis_in);
                waited++;
            end
            if (!s_ready) begin
                $display("input beat never accepted within 200 cycles");
                other_err++;
                timed_out = 1'b1;
            end
            @(negedge axis_in);
        end
        s_valid = 1'b0;
    endtask

    task automatic drain_words();
        int waited;
        waited = 0;
        while ((exp_q.size() > 0 || m_valid) && waited < 400) begin
            @(negedge axis_in);
            waited++;
        end
        if (exp_q.size() > 0 || m_valid) begin
            $display("expected output words never drained within 400 cycles");
            other_err++;
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int i, waited;
        s_beat = '0;
        s_valid = 1'b0;
        m_ready = 1'b0;
        {cur_cnt, rdy_idx, edge_cnt, close_edge, exp_total, rx_count} = '0;
        {payload_err, sideband_err, assert_err, other_err} = '0;
        {mv_prev, lat_mode, lat_check, timed_out} = '0;
        // Sink stalls about one cycle in three
        for (i = 0; i < 1024; i++) begin
            rdy_pat[i] = ($unsigned($random(seed)) % 3) != 0;
        end
        gen_words(60);

        waited = 0;
        while (rst_n !== 1'b1 && waited < 20) begin
            @(negedge axis_in);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset never released within 20 cycles");
            other_err++;
            timed_out = 1'b1;
        end
        check_flag("m_valid after reset", 1'b0, m_valid);
        check_flag("s_ready after reset", 1'b1, s_ready);

        // Random gaps and back-pressure
        if (!timed_out) send_all();
        if (!timed_out) drain_words();

        // Sink always ready, latency checked per word
        lat_mode = 1'b1;
        repeat (2) @(negedge axis_in);
        lat_check = 1'b1;
        gen_words(20);
        if (!timed_out) send_all();
        if (!timed_out) drain_words();

        check_count("word count", exp_total, rx_count);
        // Failures of the bound handshake assertions
        assert_err = dut0.chk0.fail_cnt;
        $display("errors: payload %0d, sideband %0d, assertion %0d, other %0d",
                 payload_err, sideband_err, assert_err, other_err);
        if (payload_err + sideband_err + assert_err + other_err == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== tb_clk_gen.sv ====
/* Testbench clock and reset source
   40 ns clock, reset low over the first four rising edges */

`timescale 1ns/1ps

module tb_clk_gen (
    output logic axis_in,
    output logic rst_n
);

    // Half period of 20 ns
    initial begin
        axis_in = 1'b0;
        forever #20 axis_in = ~axis_in;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge axis_in);
        @(negedge axis_in);
        rst_n = 1'b1;
    end

endmodule

// ==== verilog.f ====
axis_adapt_pkg.sv
axis_subword_counter.sv
axis_pack_ctrl.sv
axis_pack_shifter.sv
axis_word_out_reg.sv
axis_upsizer.sv
axis_upsizer_chk.sv
tb_clk_gen.sv
tb_axis_upsizer.sv
